/* include/mmu_settings.svh */
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// joint tlb geometry
`define TLB_ENTRIES 16
`define TLB_IDX_W   4

// address fields
`define VPN2_W      19
`define PFN_W       20
`define ASID_W      8
`define PAGE_OFS_W  12

`endif

/* project.f */
+incdir+include
rtl/tlb_pkg.sv
rtl/cp0_pkg.sv
rtl/tlb_array.sv
rtl/tlb_lookup.sv
rtl/cp0_tlb_regs.sv
rtl/mmu_top.sv
sim/tb_mmu.sv

/* rtl/cp0_pkg.sv */
`include "mmu_settings.svh"

package cp0_pkg;

    typedef enum logic [2:0] {
        sel_index    = 3'd0,
        sel_random   = 3'd1,
        sel_entrylo0 = 3'd2,
        sel_entrylo1 = 3'd3,
        sel_entryhi  = 3'd4
    } cp0_sel_e;

    typedef enum logic [2:0] {
        op_nop   = 3'd0,
        op_mtc0  = 3'd1,
        op_mfc0  = 3'd2,
        op_tlbp  = 3'd3,
        op_tlbr  = 3'd4,
        op_tlbwi = 3'd5,
        op_tlbwr = 3'd6
    } tlb_op_e;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [4:0]         zero;
        logic [`ASID_W-1:0] asid;
    } cp0_hi_t;

    typedef struct packed {
        logic [5:0]        zero;
        logic [`PFN_W-1:0] pfn;
        logic [2:0]        c;
        logic              d;
        logic              v;
        logic              g;
    } cp0_lo_t;

    // same 32 bits, decoded by the register it targets
    typedef union packed {
        cp0_hi_t hi;
        cp0_lo_t lo;
    } cp0_word_u;

    typedef struct packed {
        tlb_op_e   op;
        cp0_sel_e  sel;
        cp0_word_u data;
    } cp0_req_t;

    typedef struct packed {
        logic      valid;
        cp0_word_u data;
    } cp0_resp_t;

endpackage

/* rtl/cp0_tlb_regs.sv */
`include "mmu_settings.svh"

module cp0_tlb_regs (
    input  logic                    aclk,
    input  logic                    rst,
    input  cp0_pkg::cp0_req_t       req,
    output cp0_pkg::cp0_resp_t      resp,
    output logic [`ASID_W-1:0]      asid,
    output tlb_pkg::xlat_req_t      probe_req,
    input  tlb_pkg::xlat_resp_t     probe_resp,
    output logic                    tlb_we,
    output logic [`TLB_IDX_W-1:0]   tlb_w_idx,
    output tlb_pkg::tlb_entry_t     tlb_w_entry,
    output logic [`TLB_IDX_W-1:0]   tlb_r_idx,
    input  tlb_pkg::tlb_entry_t     tlb_r_entry
);
    import tlb_pkg::*;
    import cp0_pkg::*;

    // EntryHi
    logic [`VPN2_W-1:0]    vpn2_q;
    logic [`ASID_W-1:0]    asid_q;
    // EntryLo0/1, each with its own g
    tlb_lo_t               lo0_q;
    tlb_lo_t               lo1_q;
    logic                  g0_q;
    logic                  g1_q;
    // Index: probe-fail bit and index
    logic                  index_p_q;
    logic [`TLB_IDX_W-1:0] index_q;
    logic [`TLB_IDX_W-1:0] random_q;

    tlb_lo_t               wr_lo;
    cp0_word_u             rd_word;
    logic                  rd_valid_q;
    cp0_word_u             rd_data_q;

    assign wr_lo = '{pfn: req.data.lo.pfn, c: req.data.lo.c, d: req.data.lo.d,
                     v: req.data.lo.v};

    always_ff @(posedge aclk) begin
        if (rst) begin
            vpn2_q    <= '0;
            asid_q    <= '0;
            lo0_q     <= '0;
            lo1_q     <= '0;
            g0_q      <= 1'b0;
            g1_q      <= 1'b0;
            index_p_q <= 1'b0;
            index_q   <= '0;
        end else begin
            if (probe_resp.valid) begin
                index_p_q <= ~probe_resp.hit;
                index_q   <= probe_resp.idx;   // zero on a miss
            end
            case (req.op)
                op_mtc0: begin
                    case (req.sel)
                        sel_index: begin
                            index_p_q <= 1'b0;
                            index_q   <= req.data[`TLB_IDX_W-1:0];
                        end
                        sel_entrylo0: begin
                            lo0_q <= wr_lo;
                            g0_q  <= req.data.lo.g;
                        end
                        sel_entrylo1: begin
                            lo1_q <= wr_lo;
                            g1_q  <= req.data.lo.g;
                        end
                        sel_entryhi: begin
                            vpn2_q <= req.data.hi.vpn2;
                            asid_q <= req.data.hi.asid;
                        end
                        default: ;   // random is read-only
                    endcase
                end
                op_tlbr: begin
                    vpn2_q <= tlb_r_entry.vpn2;
                    asid_q <= tlb_r_entry.asid;
                    lo0_q  <= tlb_r_entry.lo0;
                    lo1_q  <= tlb_r_entry.lo1;
                    g0_q   <= tlb_r_entry.g;
                    g1_q   <= tlb_r_entry.g;
                end
                default: ;
            endcase
        end
    end

    // free-running, wraps 0 -> 15
    always_ff @(posedge aclk) begin
        if (rst) begin
            random_q <= '1;
        end else begin
            random_q <= random_q - 1'b1;
        end
    end

    always_comb begin
        rd_word = '0;
        case (req.sel)
            sel_index: begin
                rd_word[31]               = index_p_q;
                rd_word[`TLB_IDX_W-1:0]   = index_q;
            end
            sel_random: rd_word[`TLB_IDX_W-1:0] = random_q;
            sel_entrylo0: begin
                rd_word.lo.pfn = lo0_q.pfn;
                rd_word.lo.c   = lo0_q.c;
                rd_word.lo.d   = lo0_q.d;
                rd_word.lo.v   = lo0_q.v;
                rd_word.lo.g   = g0_q;
            end
            sel_entrylo1: begin
                rd_word.lo.pfn = lo1_q.pfn;
                rd_word.lo.c   = lo1_q.c;
                rd_word.lo.d   = lo1_q.d;
                rd_word.lo.v   = lo1_q.v;
                rd_word.lo.g   = g1_q;
            end
            sel_entryhi: begin
                rd_word.hi.vpn2 = vpn2_q;
                rd_word.hi.asid = asid_q;
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= (req.op == op_mfc0);
        end
    end

    always_ff @(posedge aclk) begin
        rd_data_q <= rd_word;
    end

    assign resp.valid = rd_valid_q;
    assign resp.data  = rd_data_q;

    assign asid = asid_q;

    // probe address is EntryHi vpn2 on an even page, offset zero
    assign probe_req.valid = (req.op == op_tlbp);
    assign probe_req.vaddr = {vpn2_q, {(`PAGE_OFS_W + 1){1'b0}}};

    assign tlb_we      = (req.op == op_tlbwi) || (req.op == op_tlbwr);
    assign tlb_w_idx   = (req.op == op_tlbwr) ? random_q : index_q;
    assign tlb_w_entry = '{vpn2: vpn2_q, asid: asid_q, g: g0_q & g1_q,
                           lo0: lo0_q, lo1: lo1_q};
    assign tlb_r_idx   = index_q;

endmodule

/* rtl/mmu_top.sv */
`include "mmu_settings.svh"

module mmu_top (
    input  logic                aclk,
    input  logic                rst,
    input  cp0_pkg::cp0_req_t   cp0_req,
    output cp0_pkg::cp0_resp_t  cp0_resp,
    input  tlb_pkg::xlat_req_t  itlb_req,
    output tlb_pkg::xlat_resp_t itlb_resp,
    input  tlb_pkg::xlat_req_t  dtlb_req,
    output tlb_pkg::xlat_resp_t dtlb_resp
);
    import tlb_pkg::*;

    logic [`ASID_W-1:0]    asid;
    xlat_req_t             probe_req;
    xlat_resp_t            probe_resp;
    logic                  tlb_we;
    logic [`TLB_IDX_W-1:0] tlb_w_idx;
    logic [`TLB_IDX_W-1:0] tlb_r_idx;
    tlb_entry_t            tlb_w_entry;
    tlb_entry_t            tlb_r_entry;
    tlb_entry_array_t      entries;

    cp0_tlb_regs u_cp0_tlb_regs (
        .aclk        (aclk),
        .rst         (rst),
        .req         (cp0_req),
        .resp        (cp0_resp),
        .asid        (asid),
        .probe_req   (probe_req),
        .probe_resp  (probe_resp),
        .tlb_we      (tlb_we),
        .tlb_w_idx   (tlb_w_idx),
        .tlb_w_entry (tlb_w_entry),
        .tlb_r_idx   (tlb_r_idx),
        .tlb_r_entry (tlb_r_entry)
    );

    tlb_array u_tlb_array (
        .aclk    (aclk),
        .rst     (rst),
        .we      (tlb_we),
        .w_idx   (tlb_w_idx),
        .w_entry (tlb_w_entry),
        .r_idx   (tlb_r_idx),
        .r_entry (tlb_r_entry),
        .entries (entries)
    );

    // fetch port
    tlb_lookup u_itlb (
        .aclk    (aclk),
        .rst     (rst),
        .entries (entries),
        .asid    (asid),
        .req     (itlb_req),
        .resp    (itlb_resp)
    );

    // load/store port
    tlb_lookup u_dtlb (
        .aclk    (aclk),
        .rst     (rst),
        .entries (entries),
        .asid    (asid),
        .req     (dtlb_req),
        .resp    (dtlb_resp)
    );

    tlb_lookup u_probe (
        .aclk    (aclk),
        .rst     (rst),
        .entries (entries),
        .asid    (asid),
        .req     (probe_req),
        .resp    (probe_resp)
    );

endmodule

/* rtl/tlb_array.sv */
`include "mmu_settings.svh"

module tlb_array (
    input  logic                      aclk,
    input  logic                      rst,
    input  logic                      we,
    input  logic [`TLB_IDX_W-1:0]     w_idx,
    input  tlb_pkg::tlb_entry_t       w_entry,
    input  logic [`TLB_IDX_W-1:0]     r_idx,
    output tlb_pkg::tlb_entry_t       r_entry,
    output tlb_pkg::tlb_entry_array_t entries
);
    import tlb_pkg::*;

    tlb_entry_array_t mem_q;

    // one entry per cycle from tlbwi/tlbwr
    always_ff @(posedge aclk) begin
        if (rst) begin
            mem_q <= '0;
        end else if (we) begin
            mem_q[w_idx] <= w_entry;
        end
    end

    assign r_entry = mem_q[r_idx];   // tlbr path
    assign entries = mem_q;          // flat copy for the matchers

endmodule

/* rtl/tlb_lookup.sv */
`include "mmu_settings.svh"

module tlb_lookup (
    input  logic                      aclk,
    input  logic                      rst,
    input  tlb_pkg::tlb_entry_array_t entries,
    input  logic [`ASID_W-1:0]        asid,
    input  tlb_pkg::xlat_req_t        req,
    output tlb_pkg::xlat_resp_t       resp
);
    import tlb_pkg::*;

    logic [`TLB_ENTRIES-1:0] match;
    logic                    hit;
    logic [`TLB_IDX_W-1:0]   hit_idx;
    tlb_entry_t              hit_entry;
    tlb_lo_t                 page;
    xlat_resp_t              resp_d;

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = (entries[i].vpn2 == req.vaddr[`VPN2_W+`PAGE_OFS_W -: `VPN2_W]) &&
                       (entries[i].g || (entries[i].asid == asid));
        end
    end

    // scan downwards so the lowest matching index is the last one kept
    always_comb begin
        hit_idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = i[`TLB_IDX_W-1:0];
            end
        end
    end

    assign hit       = |match;
    assign hit_entry = entries[hit_idx];
    assign page      = req.vaddr[`PAGE_OFS_W] ? hit_entry.lo1 : hit_entry.lo0;  // odd page

    always_comb begin
        resp_d       = '0;
        resp_d.valid = req.valid;
        if (req.valid && hit) begin
            resp_d.hit   = 1'b1;
            resp_d.idx   = hit_idx;
            resp_d.v     = page.v;
            resp_d.d     = page.d;
            resp_d.c     = page.c;
            resp_d.paddr = {page.pfn, req.vaddr[`PAGE_OFS_W-1:0]};
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            resp <= '0;
        end else begin
            resp <= resp_d;
        end
    end

endmodule

/* rtl/tlb_pkg.sv */
`include "mmu_settings.svh"

package tlb_pkg;

    // one page of the even/odd pair
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic [2:0]        c;    // cache attribute
        logic              d;
        logic              v;
    } tlb_lo_t;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [`ASID_W-1:0] asid;
        logic               g;
        tlb_lo_t            lo0;
        tlb_lo_t            lo1;
    } tlb_entry_t;

    typedef tlb_entry_t [`TLB_ENTRIES-1:0] tlb_entry_array_t;

    typedef struct packed {
        logic                                 valid;
        logic [`VPN2_W+`PAGE_OFS_W:0]         vaddr;
    } xlat_req_t;

    typedef struct packed {
        logic                          valid;
        logic                          hit;
        logic [`TLB_IDX_W-1:0]         idx;
        logic                          v;
        logic                          d;
        logic [2:0]                    c;
        logic [`PFN_W+`PAGE_OFS_W-1:0] paddr;
    } xlat_resp_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
# build and run the tlb testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_mmu -f project.f -o tb_mmu_sim \
    && ./obj_dir/tb_mmu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

/* sim/tb_mmu.sv */
module tb_mmu;
    import tlb_pkg::*;
    import cp0_pkg::*;

    localparam int MAX_CYCLES = 2000;   // tests take about 160 cycles
    localparam int RST_CYCLES = 16;

    logic       aclk = 1'b0;
    logic       rst;
    cp0_req_t   cp0_req;
    cp0_resp_t  cp0_resp;
    xlat_req_t  itlb_req;
    xlat_resp_t itlb_resp;
    xlat_req_t  dtlb_req;
    xlat_resp_t dtlb_resp;

    logic [31:0] seed = 32'hced3_34a6;
    int          err_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          cycles = 0;

    // cp0 words written for each tlbwi slot
    logic [31:0] hi_w [4];
    logic [31:0] lo0_w [4];
    logic [31:0] lo1_w [4];

    mmu_top u_mmu_top (
        .aclk      (aclk),
        .rst       (rst),
        .cp0_req   (cp0_req),
        .cp0_resp  (cp0_resp),
        .itlb_req  (itlb_req),
        .itlb_resp (itlb_resp),
        .dtlb_req  (dtlb_req),
        .dtlb_resp (dtlb_resp)
    );

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        seed = xorshift(seed);
        return seed;
    endfunction

    // Random seen by a request issued now: 15 after reset, one step down per edge
    function automatic logic [3:0] random_next();
        return 4'(15 - (cycles - RST_CYCLES));
    endfunction

    function automatic logic [3:0] slot_index(input int k);
        return 4'(4 * k + 2);
    endfunction

    // EntryHi: vpn2 | 5 zero bits | asid
    function automatic logic [31:0] hi_word(input logic [18:0] vpn2, input logic [7:0] asid);
        return {vpn2, 5'b0, asid};
    endfunction

    // EntryLo: 6 zero bits | pfn | c | d | v | g
    function automatic logic [31:0] lo_word(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    // tlbr returns the entry g, the AND of both written g bits
    function automatic logic [31:0] lo_readback(input logic [31:0] lo, input int k);
        return {lo[31:1], lo0_w[k][0] & lo1_w[k][0]};
    endfunction

    function automatic xlat_resp_t hit_resp(input int k, input logic [31:0] va);
        xlat_resp_t  e;
        logic [31:0] lo;
        lo = va[12] ? lo1_w[k] : lo0_w[k];   // odd page
        e = '0;
        e.valid = 1'b1;
        e.hit   = 1'b1;
        e.idx   = slot_index(k);
        e.v     = lo[1];
        e.d     = lo[2];
        e.c     = lo[5:3];
        e.paddr = {lo[25:6], va[11:0]};
        return e;
    endfunction

    function automatic xlat_resp_t miss_resp();
        xlat_resp_t e;
        e = '0;
        e.valid = 1'b1;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %-12s done, %0d errors so far", name, err_count);
    endtask

    task automatic cp0_issue(input tlb_op_e op, input cp0_sel_e sel, input logic [31:0] d);
        cp0_req.op   = op;
        cp0_req.sel  = sel;
        cp0_req.data = d;
        @(negedge aclk);
        cp0_req = '0;
    endtask

    task automatic cp0_write(input cp0_sel_e sel, input logic [31:0] d);
        cp0_issue(op_mtc0, sel, d);
    endtask

    // data must come one cycle later and stay for one cycle only
    task automatic mfc0_read(input cp0_sel_e sel, output logic [31:0] d);
        cp0_issue(op_mfc0, sel, 32'd0);
        check_value("cp0_resp.valid", 64'(cp0_resp.valid), 64'd1);
        d = cp0_resp.data;
        @(negedge aclk);
        check_value("cp0_resp.valid", 64'(cp0_resp.valid), 64'd0);
    endtask

    task automatic expect_reg(input string name, input cp0_sel_e sel, input logic [31:0] exp);
        logic [31:0] w;
        mfc0_read(sel, w);
        check_value(name, 64'(w), 64'(exp));
    endtask

    task automatic expect_random();
        logic [31:0] w;
        logic [31:0] exp;
        exp = {28'd0, random_next()};
        mfc0_read(sel_random, w);
        check_value("random", 64'(w), 64'(exp));
    endtask

    task automatic probe_index(input logic [31:0] hi, input logic [31:0] exp);
        cp0_write(sel_entryhi, hi);
        cp0_issue(op_tlbp, sel_index, 32'd0);
        @(negedge aclk);   // index lands two edges after tlbp
        expect_reg("index", sel_index, exp);
    endtask

    task automatic xlat_pair(input logic [31:0] iva, input xlat_resp_t iexp,
                             input logic [31:0] dva, input xlat_resp_t dexp);
        itlb_req.valid = 1'b1;
        itlb_req.vaddr = iva;
        dtlb_req.valid = 1'b1;
        dtlb_req.vaddr = dva;
        @(negedge aclk);
        itlb_req = '0;
        dtlb_req = '0;
        check_value("itlb_resp", 64'(itlb_resp), 64'(iexp));
        check_value("dtlb_resp", 64'(dtlb_resp), 64'(dexp));
        @(negedge aclk);
        check_value("itlb_resp.valid", 64'(itlb_resp.valid), 64'd0);
        check_value("dtlb_resp.valid", 64'(dtlb_resp.valid), 64'd0);
    endtask

    task automatic test_reset();
        check_value("itlb_resp.valid", 64'(itlb_resp.valid), 64'd0);
        check_value("dtlb_resp.valid", 64'(dtlb_resp.valid), 64'd0);
        check_value("cp0_resp.valid", 64'(cp0_resp.valid), 64'd0);
        expect_reg("index", sel_index, 32'd0);
        expect_reg("entryhi", sel_entryhi, 32'd0);
        expect_reg("entrylo0", sel_entrylo0, 32'd0);
        expect_reg("entrylo1", sel_entrylo1, 32'd0);
        expect_random();
        end_test("reset");
    endtask

    task automatic test_write_ones();
        cp0_write(sel_index, 32'hffff_ffff);
        expect_reg("index", sel_index, 32'h0000_000f);
        cp0_write(sel_entryhi, 32'hffff_ffff);
        expect_reg("entryhi", sel_entryhi, 32'hffff_e0ff);
        cp0_write(sel_entrylo0, 32'hffff_ffff);
        expect_reg("entrylo0", sel_entrylo0, 32'h03ff_ffff);
        cp0_write(sel_entrylo1, 32'hffff_ffff);
        expect_reg("entrylo1", sel_entrylo1, 32'h03ff_ffff);
        cp0_write(sel_random, 32'hffff_ffff);   // read-only
        expect_random();
        end_test("mtc0_mfc0");
    endtask

    task automatic test_tlbwi_tlbr();
        logic [31:0] r;
        for (int k = 0; k < 4; k++) begin
            r = rand32();
            hi_w[k] = hi_word(r[18:0], r[26:19] | 8'h01);
            r = rand32();
            lo0_w[k] = lo_word(r[19:0], r[22:20], r[23], r[24], k != 3);
            r = rand32();
            lo1_w[k] = lo_word(r[19:0], r[22:20], r[23], r[24], k == 1);
            cp0_write(sel_entryhi, hi_w[k]);
            cp0_write(sel_entrylo0, lo0_w[k]);
            cp0_write(sel_entrylo1, lo1_w[k]);
            cp0_write(sel_index, {28'd0, slot_index(k)});
            cp0_issue(op_tlbwi, sel_index, 32'd0);
        end
        for (int k = 0; k < 4; k++) begin
            cp0_write(sel_index, {28'd0, slot_index(k)});
            cp0_issue(op_tlbr, sel_index, 32'd0);
            expect_reg("entryhi", sel_entryhi, hi_w[k]);
            expect_reg("entrylo0", sel_entrylo0, lo_readback(lo0_w[k], k));
            expect_reg("entrylo1", sel_entrylo1, lo_readback(lo1_w[k], k));
        end
        end_test("tlbwi_tlbr");
    endtask

    task automatic test_tlbp();
        for (int k = 0; k < 4; k++) begin
            probe_index(hi_w[k], {28'd0, slot_index(k)});
        end
        // slot 1 is global, slot 0 is not
        probe_index({hi_w[1][31:8], hi_w[1][7:0] ^ 8'h80}, {28'd0, slot_index(1)});
        probe_index({hi_w[0][31:8], hi_w[0][7:0] ^ 8'h80}, 32'h8000_0000);
        probe_index(hi_word(19'd0, 8'h33), 32'h8000_0000);
        end_test("tlbp");
    endtask

    task automatic test_translate();
        logic [31:0] r;
        logic [31:0] va_even;
        logic [31:0] va_odd;
        r = rand32();
        va_even = {hi_w[0][31:13], 1'b0, r[11:0]};
        va_odd  = {hi_w[0][31:13], 1'b1, r[23:12]};
        cp0_write(sel_entryhi, hi_w[0]);
        xlat_pair(va_even, hit_resp(0, va_even), va_odd, hit_resp(0, va_odd));
        xlat_pair(va_odd, hit_resp(0, va_odd), va_even, hit_resp(0, va_even));
        // other asid: slot 0 misses, global slot 1 still hits
        cp0_write(sel_entryhi, {hi_w[0][31:8], hi_w[0][7:0] ^ 8'h80});
        va_odd = {hi_w[1][31:13], 1'b1, r[31:20]};
        xlat_pair(va_even, miss_resp(), va_odd, hit_resp(1, va_odd));
        end_test("translate");
    endtask

    task automatic test_tlbwr();
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo0;
        logic [31:0] lo1;
        logic [31:0] w;
        logic [31:0] wr_idx;
        r = rand32();
        hi = hi_word(r[18:0], r[26:19] | 8'h01);
        r = rand32();
        lo0 = lo_word(r[19:0], r[22:20], r[23], r[24], 1'b1);
        r = rand32();
        lo1 = lo_word(r[19:0], r[22:20], r[23], r[24], r[25]);
        cp0_write(sel_entryhi, hi);
        cp0_write(sel_entrylo0, lo0);
        cp0_write(sel_entrylo1, lo1);
        wr_idx = {28'd0, random_next()};
        cp0_issue(op_tlbwr, sel_index, 32'd0);
        cp0_issue(op_tlbp, sel_index, 32'd0);
        cp0_write(sel_entryhi, 32'd0);   // tlbr has to refill these
        cp0_write(sel_entrylo0, 32'd0);
        cp0_write(sel_entrylo1, 32'd0);
        mfc0_read(sel_index, w);
        check_value("index", 64'(w), 64'(wr_idx));
        cp0_issue(op_tlbr, sel_index, 32'd0);
        expect_reg("entryhi", sel_entryhi, hi);
        expect_reg("entrylo0", sel_entrylo0, {lo0[31:1], lo0[0] & lo1[0]});
        expect_reg("entrylo1", sel_entrylo1, {lo1[31:1], lo0[0] & lo1[0]});
        end_test("tlbwr");
    endtask

    initial begin
        rst      = 1'b1;
        cp0_req  = '0;
        itlb_req = '0;
        dtlb_req = '0;
        repeat (RST_CYCLES) @(negedge aclk);
        rst = 1'b0;
        test_reset();
        test_write_ones();
        test_tlbwi_tlbr();
        test_tlbp();
        test_translate();
        test_tlbwr();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
